// File: design/circle_raster.sv
`timescale 1ns/1ps
`default_nettype none

module circle_raster #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  raster_pkg::colour_t  colour,
	input  raster_pkg::coord_x_t centre_x,
	input  raster_pkg::coord_y_t centre_y,
	input  raster_pkg::coord_x_t radius,
	output logic                 done,
	output raster_pkg::pixel_t   pixel,
	output logic                 plot
);

	typedef enum logic [3:0] {
		IDLE,
		OCT1,
		OCT2,
		OCT3,
		OCT4,
		OCT5,
		OCT6,
		OCT7,
		OCT8,
		FINISHED
	} state_t;

	state_t state;

	// Offsets are signed so that radius 0 steps x below zero and ends the sweep.
	logic signed [9:0]  off_x;
	logic signed [9:0]  off_y;
	logic signed [11:0] crit;

	logic signed [9:0]  cx;
	logic signed [9:0]  cy;
	logic signed [9:0]  px;
	logic signed [9:0]  py;
	logic signed [9:0]  nx;
	logic signed [9:0]  ny;
	logic signed [11:0] nx_w;
	logic signed [11:0] ny_w;
	logic               on_screen;

	assign cx = $signed({2'b00, centre_x});
	assign cy = $signed({3'b000, centre_y});
	assign nx = off_x - 10'sd1;
	assign ny = off_y + 10'sd1;
	assign nx_w = {{2{nx[9]}}, nx};
	assign ny_w = {{2{ny[9]}}, ny};

	// Mirror the current offset pair into the octant of this cycle.
	always_comb begin
		px = cx;
		py = cy;
		case (state)
			OCT1: begin px = cx + off_x; py = cy + off_y; end
			OCT2: begin px = cx + off_y; py = cy + off_x; end
			OCT3: begin px = cx - off_y; py = cy + off_x; end
			OCT4: begin px = cx - off_x; py = cy + off_y; end
			OCT5: begin px = cx - off_x; py = cy - off_y; end
			OCT6: begin px = cx - off_y; py = cy - off_x; end
			OCT7: begin px = cx + off_y; py = cy - off_x; end
			OCT8: begin px = cx + off_x; py = cy - off_y; end
			default: ;
		endcase
	end

	assign on_screen = (px >= 10'sd0) && (px < SCREEN_W) && (py >= 10'sd0) && (py < SCREEN_H);

	assign plot = (state != IDLE) && (state != FINISHED) && on_screen && (off_y <= off_x);
	assign done = (state == FINISHED);
	assign pixel = '{x: px[7:0], y: py[6:0], colour: colour};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (!start) begin
			state <= IDLE; // Abort from anywhere.
		end else begin
			case (state)
				IDLE: state <= OCT1;
				OCT1: state <= (off_y <= off_x) ? OCT2 : FINISHED;
				OCT2: state <= OCT3;
				OCT3: state <= OCT4;
				OCT4: state <= OCT5;
				OCT5: state <= OCT6;
				OCT6: state <= OCT7;
				OCT7: state <= OCT8;
				OCT8: state <= OCT1;
				FINISHED: state <= FINISHED; // Held until start drops.
				default: state <= IDLE;
			endcase
		end
	end

	// Midpoint step, using the already advanced offsets.
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			off_x <= $signed({2'b00, radius});
			off_y <= '0;
			crit  <= 12'sd1 - $signed({4'b0000, radius});
		end else if (state == OCT8) begin
			off_y <= ny;
			if (crit < 12'sd1) begin
				crit <= crit + (ny_w <<< 1) + 12'sd1;
			end else begin
				off_x <= nx;
				crit  <= crit + ((ny_w - nx_w) <<< 1) + 12'sd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/draw_engine.sv
`timescale 1ns/1ps
`default_nettype none

module draw_engine (
	input  logic                clk,
	input  logic                rst_n,
	input  draw_pkg::draw_cmd_t cmd,
	input  logic                req,
	output logic                ack,
	output logic                fill_start,
	output logic                circ_start,
	input  logic                fill_done,
	input  logic                circ_done,
	input  raster_pkg::pixel_t  fill_pixel,
	input  raster_pkg::pixel_t  circ_pixel,
	input  logic                fill_plot,
	input  logic                circ_plot,
	output raster_pkg::pixel_t  wr_pixel,
	output logic                wr_en
);

	typedef enum logic [1:0] {
		IDLE,
		DRAWING,
		ACKED
	} state_t;

	state_t             state;
	draw_pkg::draw_op_t op_q; // Opcode of the command in progress.
	logic               is_clear;
	logic               gen_done;

	assign is_clear = (op_q == draw_pkg::OP_CLEAR);
	assign gen_done = is_clear ? fill_done : circ_done;

	// Start is held through the ack phase so done stays up.
	assign fill_start = (state != IDLE) && is_clear;
	assign circ_start = (state != IDLE) && !is_clear;
	assign ack = (state == ACKED);

	// Idle generator never plots.
	assign wr_pixel = is_clear ? fill_pixel : circ_pixel;
	assign wr_en = is_clear ? fill_plot : circ_plot;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			op_q  <= draw_pkg::OP_CLEAR;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						op_q  <= cmd.op;
						state <= DRAWING;
					end
				end
				DRAWING: begin
					if (gen_done) state <= ACKED;
				end
				ACKED: begin
					if (!req) state <= IDLE; // Four-phase return to zero.
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/draw_pkg.sv
`default_nettype none

package draw_pkg;

	// Drawing operations accepted from the host.
	typedef enum logic {
		OP_CLEAR  = 1'b0, // Fill whole screen.
		OP_CIRCLE = 1'b1  // Circle outline.
	} draw_op_t;

	// Centre and radius are ignored by OP_CLEAR.
	typedef struct packed {
		draw_op_t             op;
		raster_pkg::colour_t  colour;
		raster_pkg::coord_x_t centre_x;
		raster_pkg::coord_y_t centre_y;
		raster_pkg::coord_x_t radius;
	} draw_cmd_t;

endpackage

`default_nettype wire

// File: design/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic                 clk,
	input  raster_pkg::pixel_t   wr_pixel,
	input  logic                 wr_en,
	input  raster_pkg::coord_x_t rd_x,
	input  raster_pkg::coord_y_t rd_y,
	output raster_pkg::colour_t  rd_colour
);

	localparam int DEPTH = SCREEN_W * SCREEN_H;
	localparam int AW = $clog2(DEPTH);

	raster_pkg::colour_t mem [DEPTH];

	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	// Row-major layout.
	assign wr_addr = AW'(int'(wr_pixel.y) * SCREEN_W + int'(wr_pixel.x));
	assign rd_addr = AW'(int'(rd_y) * SCREEN_W + int'(rd_x));

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_pixel.colour;
		end
	end

	// Scan-out port, one cycle of latency.
	always_ff @(posedge clk) begin
		rd_colour <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: design/raster_pkg.sv
`default_nettype none

package raster_pkg;

	// Horizontal position on the raster, up to 256 columns.
	typedef logic [7:0] coord_x_t;

	// Vertical position on the raster, up to 128 rows.
	typedef logic [6:0] coord_y_t;

	// 3-bit RGB, one bit per gun.
	typedef logic [2:0] colour_t;

	// One plotted pixel as it travels from a generator to the frame buffer.
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_t;

endpackage

`default_nettype wire

// File: design/screen_fill.sv
`timescale 1ns/1ps
`default_nettype none

module screen_fill #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  raster_pkg::colour_t colour,
	output logic                done,
	output raster_pkg::pixel_t  pixel,
	output logic                plot
);

	typedef enum logic [1:0] {
		IDLE,
		SWEEP,
		FINISHED
	} state_t;

	state_t               state;
	raster_pkg::coord_x_t x_cnt;
	raster_pkg::coord_y_t y_cnt;
	logic                 last_col;
	logic                 last_row;

	assign last_col = (x_cnt == raster_pkg::coord_x_t'(SCREEN_W - 1));
	assign last_row = (y_cnt == raster_pkg::coord_y_t'(SCREEN_H - 1));

	assign plot = (state == SWEEP);
	assign done = (state == FINISHED);
	assign pixel = '{x: x_cnt, y: y_cnt, colour: colour};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (!start) begin
			state <= IDLE;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			case (state)
				IDLE: state <= SWEEP;
				SWEEP: begin
					if (last_col) begin
						x_cnt <= '0;
						if (last_row) state <= FINISHED;
						else y_cnt <= y_cnt + 1'b1; // Next row.
					end else begin
						x_cnt <= x_cnt + 1'b1;
					end
				end
				FINISHED: state <= FINISHED;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/vga_circle_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_circle_top #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  draw_pkg::draw_cmd_t  cmd,
	input  logic                 req,
	output logic                 ack,
	input  raster_pkg::coord_x_t rd_x,
	input  raster_pkg::coord_y_t rd_y,
	output raster_pkg::colour_t  rd_colour
);

	logic               fill_start;
	logic               circ_start;
	logic               fill_done;
	logic               circ_done;
	raster_pkg::pixel_t fill_pixel;
	raster_pkg::pixel_t circ_pixel;
	logic               fill_plot;
	logic               circ_plot;
	raster_pkg::pixel_t wr_pixel;
	logic               wr_en;

	draw_engine engine_i (
		.clk, .rst_n, .cmd, .req, .ack,
		.fill_start, .circ_start, .fill_done, .circ_done,
		.fill_pixel, .circ_pixel, .fill_plot, .circ_plot,
		.wr_pixel, .wr_en
	);

	// Command fields come straight from the host, which holds cmd until ack.
	screen_fill #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) fill_i (
		.clk, .rst_n, .start(fill_start), .colour(cmd.colour),
		.done(fill_done), .pixel(fill_pixel), .plot(fill_plot)
	);

	circle_raster #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) circle_i (
		.clk, .rst_n, .start(circ_start), .colour(cmd.colour),
		.centre_x(cmd.centre_x), .centre_y(cmd.centre_y), .radius(cmd.radius),
		.done(circ_done), .pixel(circ_pixel), .plot(circ_plot)
	);

	frame_buffer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) fb_i (
		.clk, .wr_pixel, .wr_en, .rd_x, .rd_y, .rd_colour
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status is non-zero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_vga_circle
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f vga_circle.f \
	--top-module tb_vga_circle \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "run_sim: Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "run_sim: simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
	echo "run_sim: testbench reported failure"
	exit 1
fi

echo "run_sim: testbench passed"
exit 0

// File: test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic int pixel_index(input int x, input int y);
	return y * SCREEN_W + x;
endfunction

function automatic draw_pkg::draw_cmd_t make_cmd(input draw_pkg::draw_op_t op, input int colour,
		input int cx, input int cy, input int r);
	draw_pkg::draw_cmd_t c;
	c.op = op;
	c.colour = raster_pkg::colour_t'(colour);
	c.centre_x = raster_pkg::coord_x_t'(cx);
	c.centre_y = raster_pkg::coord_y_t'(cy);
	c.radius = raster_pkg::coord_x_t'(r);
	return c;
endfunction

task automatic fill_model(input int colour);
	for (int i = 0; i < SCREEN_PIXELS; i++) begin
		model[i] = raster_pkg::colour_t'(colour);
	end
endtask

// Points off the raster are dropped, never wrapped.
task automatic plot_model(input int x, input int y, input int colour);
	if (x >= 0 && x < SCREEN_W && y >= 0 && y < SCREEN_H) begin
		model[pixel_index(x, y)] = raster_pkg::colour_t'(colour);
	end
endtask

// Midpoint circle over all eight octants of each offset pair with y <= x.
task automatic draw_model_circle(input int cx, input int cy, input int r, input int colour);
	int x;
	int y;
	int d;
	x = r;
	y = 0;
	d = 1 - r;
	while (y <= x) begin
		plot_model(cx + x, cy + y, colour);
		plot_model(cx + y, cy + x, colour);
		plot_model(cx - y, cy + x, colour);
		plot_model(cx - x, cy + y, colour);
		plot_model(cx - x, cy - y, colour);
		plot_model(cx - y, cy - x, colour);
		plot_model(cx + y, cy - x, colour);
		plot_model(cx + x, cy - y, colour);
		y = y + 1;
		if (d <= 0) begin
			d = d + 2 * y + 1;
		end else begin
			x = x - 1;
			d = d + 2 * (y - x) + 1;
		end
	end
endtask

// Four-phase req/ack. Called and returns 1 ns after a rising edge.
task automatic send_command(input draw_pkg::draw_cmd_t c, input int hold_cycles);
	int waited;
	cmd = c;
	req = 1'b1;
	waited = 0;
	while (ack !== 1'b1 && waited < ACK_TIMEOUT) begin
		@(posedge clk);
		#1;
		waited++;
	end
	assert (ack === 1'b1) else begin
		$display("Handshake error: no ack within %0d cycles of req", ACK_TIMEOUT);
		handshake_errors++;
	end
	repeat (hold_cycles) begin
		@(posedge clk);
		#1;
		assert (ack === 1'b1) else begin
			$display("Handshake error: ack dropped while req was still high");
			handshake_errors++;
		end
	end
	req = 1'b0;
	@(posedge clk);
	#1;
	assert (ack === 1'b0) else begin
		$display("Handshake error: ack still high one cycle after req fell");
		handshake_errors++;
	end
endtask

task automatic clear_screen(input int colour);
	send_command(make_cmd(draw_pkg::OP_CLEAR, colour, 0, 0, 0), 0);
	fill_model(colour);
endtask

task automatic draw_circle(input int cx, input int cy, input int r, input int colour);
	send_command(make_cmd(draw_pkg::OP_CIRCLE, colour, cx, cy, r), 0);
	draw_model_circle(cx, cy, r, colour);
endtask

// Whole-screen readback with one pixel per cycle behind the registered read port.
task automatic check_screen(input string what);
	int exp_c;
	for (int y = 0; y < SCREEN_H; y++) begin
		for (int x = 0; x < SCREEN_W; x++) begin
			rd_x = raster_pkg::coord_x_t'(x);
			rd_y = raster_pkg::coord_y_t'(y);
			@(posedge clk);
			#1;
			exp_c = int'(model[pixel_index(x, y)]);
			assert (int'(rd_colour) == exp_c) else begin
				$display("Fail at %0t: %s pixel (%0d,%0d) expected %0d got %0d",
					$time, what, x, y, exp_c, rd_colour);
				pixel_errors++;
			end
		end
	end
endtask

task automatic reset_and_handshake();
	assert (ack === 1'b0) else begin
		$display("Fail at %0t: ack is %b after reset", $time, ack);
		handshake_errors++;
	end
	send_command(make_cmd(draw_pkg::OP_CLEAR, 0, 0, 0, 0), 5); // Host holds req a while.
	fill_model(0);
endtask

task automatic clear_to_colour();
	clear_screen(5);
	check_screen("clear");
endtask

task automatic centred_circle();
	clear_screen(0);
	draw_circle(80, 60, 40, 2);
	check_screen("centred circle");
endtask

// Wrapped points would land near the right and bottom edges.
task automatic clipped_corner_circle();
	clear_screen(0);
	draw_circle(5, 3, 30, 6);
	check_screen("clipped circle");
endtask

task automatic zero_radius_circle();
	clear_screen(0);
	draw_circle(100, 70, 0, 7);
	check_screen("zero radius");
endtask

task automatic random_circle_burst();
	int cx;
	int cy;
	int r;
	int colour;
	clear_screen(1);
	for (int n = 0; n < NUM_RANDOM; n++) begin
		cx = int'($unsigned($random(seed)) % SCREEN_W);
		cy = int'($unsigned($random(seed)) % SCREEN_H);
		r = int'($unsigned($random(seed)) % 64);
		colour = int'($unsigned($random(seed)) % 8);
		draw_circle(cx, cy, r, colour);
	end
	check_screen("random circles");
endtask

`endif

// File: test/tb_vga_circle.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_circle;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int SCREEN_PIXELS = SCREEN_W * SCREEN_H;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_RANDOM = 12;
	localparam int SEED_INIT = 83544;
	localparam int ACK_TIMEOUT = SCREEN_PIXELS + 1000;
	// Six clears and five readbacks plus the circles, doubled.
	localparam int WATCHDOG_CYCLES = 2 * (11 * SCREEN_PIXELS + (NUM_RANDOM + 3) * 1024);

	logic                 clk;
	logic                 rst_n;
	draw_pkg::draw_cmd_t  cmd;
	logic                 req;
	logic                 ack;
	raster_pkg::coord_x_t rd_x;
	raster_pkg::coord_y_t rd_y;
	raster_pkg::colour_t  rd_colour;

	int                  pixel_errors;
	int                  handshake_errors;
	integer              seed;
	raster_pkg::colour_t model [SCREEN_PIXELS]; // Expected screen contents.

	vga_circle_top #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) dut_i (
		.clk, .rst_n, .cmd, .req, .ack, .rd_x, .rd_y, .rd_colour
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		req = 1'b0;
		cmd = '0;
		rd_x = '0;
		rd_y = '0;
		pixel_errors = 0;
		handshake_errors = 0;
		seed = SEED_INIT;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_and_handshake();
		clear_to_colour();
		centred_circle();
		clipped_corner_circle();
		zero_radius_circle();
		random_circle_burst();
		$display("Errors: %0d pixel, %0d handshake", pixel_errors, handshake_errors);
		if (pixel_errors == 0 && handshake_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	`include "tb_tasks.svh"

endmodule

`default_nettype wire

// File: vga_circle.f
design/raster_pkg.sv
design/draw_pkg.sv
design/circle_raster.sv
design/screen_fill.sv
design/draw_engine.sv
design/frame_buffer.sv
design/vga_circle_top.sv
+incdir+test
test/tb_vga_circle.sv
